// ==== verilog/chess_pkg.sv ====
`default_nettype none

package chess_pkg;

   localparam int EVAL_WIDTH = 16;

   // Piece kinds, low three bits of a square
   localparam logic [2:0] EMPTY  = 3'd0;
   localparam logic [2:0] PAWN   = 3'd1;
   localparam logic [2:0] KNIGHT = 3'd2;
   localparam logic [2:0] BISHOP = 3'd3;
   localparam logic [2:0] ROOK   = 3'd4;
   localparam logic [2:0] QUEEN  = 3'd5;
   localparam logic [2:0] KING   = 3'd6;

   // Indexed by kind, slot 7 unused
   localparam int MG_VALUE [8] = '{0, 100, 320, 330, 500, 950, 0, 0};
   localparam int EG_VALUE [8] = '{0, 120, 300, 320, 530, 980, 0, 0};
   localparam int MAT_VALUE [8] = '{0, 1, 3, 3, 5, 9, 0, 0};

   localparam int PAWN_ADV_MG = 5;
   localparam int PAWN_ADV_EG = 10;
   localparam int DOUBLED_MG = 15;
   localparam int DOUBLED_EG = 25;

   localparam int PHASE_MAX = 30;
   localparam int PHASE_RECIP = 34952;   // floor(2**20 / 30)
   localparam int PHASE_SHIFT = 20;

   // Blend pipeline sizing
   localparam int BLEND_CYCLES = 4;
   localparam int SUM_WIDTH = EVAL_WIDTH + 2;    // Three partials
   localparam int PROD_WIDTH = SUM_WIDTH + 6;    // Times a 0..30 weight
   localparam int BLEND_WIDTH = PROD_WIDTH + 1;
   localparam int SCALE_WIDTH = BLEND_WIDTH + 17; // Times the reciprocal

   typedef struct packed {
      logic       black;
      logic [2:0] kind;
   } piece_t;

   typedef piece_t [63:0] board_t;   // Index is rank * 8 + file

   typedef struct packed {
      board_t board;
      logic   white_to_move;
   } eval_req_t;

   typedef struct packed {
      logic signed [EVAL_WIDTH-1:0] eval;
      logic signed [15:0]           material;
      logic                         insufficient_material;
   } eval_result_t;

endpackage

`default_nettype wire

// ==== verilog/popcount.sv ====
`default_nettype none

module popcount
(
   input  logic        clk,
   input  logic [63:0] mask,
   output logic [6:0]  population
);

   logic [3:0] byte_sum [8];
   logic [3:0] byte_count [8];   // Stage one registers
   logic [6:0] total;

   always_comb
   begin
      for (int b = 0; b < 8; b++)
      begin
         byte_sum[b] = 4'd0;
         for (int i = 0; i < 8; i++)
            byte_sum[b] = byte_sum[b] + 4'(mask[b * 8 + i]);
      end
   end

   always_comb
   begin
      total = 7'd0;
      for (int b = 0; b < 8; b++)
         total = total + 7'(byte_count[b]);
   end

   always_ff @(posedge clk)
   begin
      byte_count <= byte_sum;
      population <= total;
   end

endmodule

`default_nettype wire

// ==== verilog/eval_material.sv ====
`default_nettype none

module eval_material
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    start,
   input  chess_pkg::board_t                       board,
   output logic                                    done,
   output logic signed [chess_pkg::EVAL_WIDTH-1:0] mg,
   output logic signed [chess_pkg::EVAL_WIDTH-1:0] eg,
   output logic signed [15:0]                      material,
   output logic                                    insufficient_material
);

   import chess_pkg::*;

   logic [2:0] rank;
   logic       busy;
   int         row_mg;
   int         row_eg;
   int         row_mat;
   int         row_heavy;   // Pawns, rooks and queens of either color
   int         row_minor;
   logic [6:0] heavy_count;
   logic [6:0] minor_count;
   logic [6:0] heavy_total;
   logic [6:0] minor_total;

   // Signed values of the rank under the scan
   always_comb
   begin
      piece_t sq;
      row_mg = 0;
      row_eg = 0;
      row_mat = 0;
      row_heavy = 0;
      row_minor = 0;
      for (int f = 0; f < 8; f++)
      begin
         sq = board[{rank, 3'(f)}];
         if (sq.black)
         begin
            row_mg = row_mg - MG_VALUE[sq.kind];
            row_eg = row_eg - EG_VALUE[sq.kind];
            row_mat = row_mat - MAT_VALUE[sq.kind];
         end
         else
         begin
            row_mg = row_mg + MG_VALUE[sq.kind];
            row_eg = row_eg + EG_VALUE[sq.kind];
            row_mat = row_mat + MAT_VALUE[sq.kind];
         end
         if (sq.kind == PAWN || sq.kind == ROOK || sq.kind == QUEEN)
            row_heavy = row_heavy + 1;
         if (sq.kind == KNIGHT || sq.kind == BISHOP)
            row_minor = row_minor + 1;
      end
   end

   assign heavy_total = heavy_count + 7'(row_heavy);
   assign minor_total = minor_count + 7'(row_minor);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         done <= 1'b0;
         rank <= 3'd0;
      end
      else if (start)
      begin
         busy <= 1'b1;
         done <= 1'b0;
         rank <= 3'd0;
      end
      else if (busy)
      begin
         rank <= rank + 3'd1;
         if (rank == 3'd7)
         begin
            busy <= 1'b0;
            done <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         mg <= '0;
         eg <= '0;
         material <= '0;
         heavy_count <= 7'd0;
         minor_count <= 7'd0;
      end
      else if (busy)
      begin
         mg <= mg + EVAL_WIDTH'(row_mg);
         eg <= eg + EVAL_WIDTH'(row_eg);
         material <= material + 16'(row_mat);
         heavy_count <= heavy_total;
         minor_count <= minor_total;
         if (rank == 3'd7)   // Kings only, plus at most one minor
            insufficient_material <= (heavy_total == 7'd0) && (minor_total <= 7'd1);
      end
   end

endmodule

`default_nettype wire

// ==== verilog/eval_pawns.sv ====
`default_nettype none

module eval_pawns
#(
   parameter bit white_pawns = 1'b1
)
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    start,
   input  chess_pkg::board_t                       board,
   output logic                                    done,
   output logic signed [chess_pkg::EVAL_WIDTH-1:0] mg,
   output logic signed [chess_pkg::EVAL_WIDTH-1:0] eg
);

   import chess_pkg::*;

   logic [2:0]         rank;
   logic               busy;
   logic [3:0]         file_count [8];   // Pawns seen per file
   logic [3:0]         next_count [8];
   logic signed [11:0] adv_sum;
   int                 row_adv;
   int                 extra;
   int                 mg_raw;
   int                 eg_raw;

   // Pawns of the scanned color on the current rank
   always_comb
   begin
      piece_t sq;
      logic   is_pawn;
      row_adv = 0;
      for (int f = 0; f < 8; f++)
      begin
         sq = board[{rank, 3'(f)}];
         is_pawn = (sq.kind == PAWN) && (sq.black != white_pawns);
         next_count[f] = file_count[f] + 4'(is_pawn);
         if (is_pawn)
            row_adv = row_adv + (white_pawns ? int'(rank) - 1 : 6 - int'(rank));
      end
   end

   // Final score, only latched on the last rank
   always_comb
   begin
      extra = 0;
      for (int f = 0; f < 8; f++)
         if (next_count[f] > 4'd1)
            extra = extra + int'(next_count[f]) - 1;
      mg_raw = (int'(adv_sum) + row_adv) * PAWN_ADV_MG - extra * DOUBLED_MG;
      eg_raw = (int'(adv_sum) + row_adv) * PAWN_ADV_EG - extra * DOUBLED_EG;
      if (!white_pawns)
      begin
         mg_raw = -mg_raw;   // Black terms count against white
         eg_raw = -eg_raw;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         done <= 1'b0;
         rank <= 3'd0;
      end
      else if (start)
      begin
         busy <= 1'b1;
         done <= 1'b0;
         rank <= 3'd0;
      end
      else if (busy)
      begin
         rank <= rank + 3'd1;
         if (rank == 3'd7)
         begin
            busy <= 1'b0;
            done <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         file_count <= '{default: 4'd0};
         adv_sum <= '0;
      end
      else if (busy)
      begin
         file_count <= next_count;
         adv_sum <= adv_sum + 12'(row_adv);
         if (rank == 3'd7)
         begin
            mg <= EVAL_WIDTH'(mg_raw);
            eg <= EVAL_WIDTH'(eg_raw);
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/evaluate.sv ====
`default_nettype none

module evaluate
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    req,
   input  chess_pkg::eval_req_t    request,
   output logic                    ack,
   output chess_pkg::eval_result_t result
);

   import chess_pkg::*;

   typedef enum logic [1:0] {IDLE, SCAN, BLEND, HOLD} state_t;

   state_t                        state;
   logic                          accept;
   logic                          start;
   logic [1:0]                    blend_count;
   board_t                        board_r;
   logic                          white_to_move_r;
   logic [63:0]                   occupied;
   logic [6:0]                    population;
   logic                          material_done;
   logic                          white_done;
   logic                          black_done;
   logic signed [EVAL_WIDTH-1:0]  mat_mg;
   logic signed [EVAL_WIDTH-1:0]  mat_eg;
   logic signed [EVAL_WIDTH-1:0]  wp_mg;
   logic signed [EVAL_WIDTH-1:0]  wp_eg;
   logic signed [EVAL_WIDTH-1:0]  bp_mg;
   logic signed [EVAL_WIDTH-1:0]  bp_eg;
   logic signed [15:0]            material_balance;
   logic                          insufficient;
   logic [4:0]                    phase;
   logic signed [SUM_WIDTH-1:0]   mg_sum;
   logic signed [SUM_WIDTH-1:0]   eg_sum;
   logic signed [PROD_WIDTH-1:0]  mg_weighted;
   logic signed [PROD_WIDTH-1:0]  eg_weighted;
   logic signed [BLEND_WIDTH-1:0] blend;
   logic signed [SCALE_WIDTH-1:0] scaled;
   logic signed [SCALE_WIDTH-1:0] bias;
   logic signed [SCALE_WIDTH-1:0] truncated;
   logic signed [EVAL_WIDTH-1:0]  eval_q;

   assign accept = (state == IDLE) && req;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= IDLE;
         start <= 1'b0;
         ack <= 1'b0;
         blend_count <= 2'd0;
      end
      else
      begin
         start <= 1'b0;
         case (state)
            IDLE:
               if (req)
               begin
                  start <= 1'b1;
                  state <= SCAN;
               end
            SCAN:   // Done flags from the last run are stale while start is high
               if (!start && material_done && white_done && black_done)
               begin
                  blend_count <= 2'd0;
                  state <= BLEND;
               end
            BLEND:
            begin
               blend_count <= blend_count + 2'd1;
               if (blend_count == 2'(BLEND_CYCLES - 1))
               begin
                  ack <= 1'b1;
                  state <= HOLD;
               end
            end
            HOLD:
               if (!req)
               begin
                  ack <= 1'b0;
                  state <= IDLE;
               end
            default:
               state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         board_r <= request.board;
         white_to_move_r <= request.white_to_move;
      end
   end

   always_comb
   begin
      for (int i = 0; i < 64; i++)
         occupied[i] = board_r[i].kind != EMPTY;
   end

   // Free-running blend, inputs hold steady once the scanners finish
   assign bias = scaled[SCALE_WIDTH-1] ? SCALE_WIDTH'((1 << PHASE_SHIFT) - 1) : '0;
   assign truncated = (scaled + bias) >>> PHASE_SHIFT;   // Toward zero

   always_ff @(posedge clk)
   begin
      mg_sum <= SUM_WIDTH'(mat_mg) + SUM_WIDTH'(wp_mg) + SUM_WIDTH'(bp_mg);
      eg_sum <= SUM_WIDTH'(mat_eg) + SUM_WIDTH'(wp_eg) + SUM_WIDTH'(bp_eg);
      phase <= (population > 7'(PHASE_MAX)) ? 5'(PHASE_MAX) : population[4:0];
      mg_weighted <= mg_sum * $signed({1'b0, phase});
      eg_weighted <= eg_sum * $signed({1'b0, 5'(PHASE_MAX) - phase});
      blend <= BLEND_WIDTH'(mg_weighted) + BLEND_WIDTH'(eg_weighted);
      scaled <= SCALE_WIDTH'(blend) * SCALE_WIDTH'(PHASE_RECIP);
      eval_q <= white_to_move_r ? truncated[EVAL_WIDTH-1:0] : -truncated[EVAL_WIDTH-1:0];
   end

   always_comb
   begin
      result.eval = eval_q;
      result.material = material_balance;
      result.insufficient_material = insufficient;
   end

   eval_material u_material
   (
      .clk                   (clk),
      .reset                 (reset),
      .start                 (start),
      .board                 (board_r),
      .done                  (material_done),
      .mg                    (mat_mg),
      .eg                    (mat_eg),
      .material              (material_balance),
      .insufficient_material (insufficient)
   );

   eval_pawns #(.white_pawns(1'b1)) u_pawns_white
   (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .board (board_r),
      .done  (white_done),
      .mg    (wp_mg),
      .eg    (wp_eg)
   );

   eval_pawns #(.white_pawns(1'b0)) u_pawns_black
   (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .board (board_r),
      .done  (black_done),
      .mg    (bp_mg),
      .eg    (bp_eg)
   );

   popcount u_occupied
   (
      .clk        (clk),
      .mask       (occupied),
      .population (population)
   );

endmodule

`default_nettype wire

// ==== verilog/eval_top.sv ====
`default_nettype none

module eval_top
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    req,
   input  chess_pkg::eval_req_t    request,
   output logic                    ack,
   output chess_pkg::eval_result_t result
);

   // Four-phase req/ack boundary of the evaluator
   evaluate u_evaluate
   (
      .clk     (clk),
      .reset   (reset),
      .req     (req),
      .request (request),
      .ack     (ack),
      .result  (result)
   );

endmodule

`default_nettype wire

// ==== test/eval_checker.sv ====
`default_nettype none

module eval_checker
(
   input logic                    clk,
   input logic                    reset,
   input logic                    req,
   input logic                    ack,
   input chess_pkg::eval_result_t result
);

   timeunit 1ns;
   timeprecision 1ps;

   int failures = 0;   // Read by the testbench at the end of the run

   // Reset leaves the handshake idle
   ack_low_after_reset: assert property (@(posedge clk) reset |=> !ack)
   else
   begin
      $error("ack is high right after reset");
      failures++;
   end

   ack_needs_req: assert property (@(posedge clk) disable iff (reset) !req && !ack |=> !ack)
   else
   begin
      $error("ack rose while req was low");
      failures++;
   end

   // Four-phase return to zero
   ack_drop: assert property (@(posedge clk) disable iff (reset) ack && !req |=> !ack)
   else
   begin
      $error("ack did not fall one cycle after req fell");
      failures++;
   end

   result_stable: assert property (@(posedge clk) disable iff (reset)
      ack |=> !ack || $stable(result))
   else
   begin
      $error("result changed while ack was high");
      failures++;
   end

endmodule

bind eval_top eval_checker u_checker
(
   .clk    (clk),
   .reset  (reset),
   .req    (req),
   .ack    (ack),
   .result (result)
);

`default_nettype wire

// ==== test/tb_eval.sv ====
`default_nettype none

module tb_eval;

   timeunit 1ns;
   timeprecision 1ps;

   import chess_pkg::*;

   localparam int REQUESTS = 45;
   localparam int REQUEST_CYCLES = 20;
   localparam int MAX_CYCLES = 2 * REQUESTS * REQUEST_CYCLES + 200;   // 2000

   logic         clk = 1'b0;
   logic         reset;
   logic         req;
   eval_req_t    request;
   logic         ack;
   eval_result_t result;
   int           errors;
   int           checks;
   int           cycles;
   int           total;
   board_t       brd;
   logic         side;

   eval_top dut
   (
      .clk     (clk),
      .reset   (reset),
      .req     (req),
      .request (request),
      .ack     (ack),
      .result  (result)
   );

   always #50 clk = ~clk;

   function automatic piece_t make_piece(input logic black, input logic [2:0] kind);
      piece_t p;
      p.black = black;
      p.kind = kind;
      return p;
   endfunction

   // Drops a piece on a random empty square between two ranks
   function automatic void place(inout board_t b, input piece_t p, input int lo, input int hi);
      int sq;
      do
         sq = $urandom_range(lo * 8, hi * 8 + 7);
      while (b[sq].kind != EMPTY);
      b[sq] = p;
   endfunction

   function automatic board_t random_board();
      board_t b;
      piece_t p;
      int     n;
      b = '0;
      place(b, make_piece(1'b0, KING), 0, 7);
      place(b, make_piece(1'b1, KING), 0, 7);
      n = $urandom_range(0, 16);   // Keeps sums inside 16 bits
      for (int i = 0; i < n; i++)
      begin
         p = make_piece(1'($urandom_range(0, 1)), 3'($urandom_range(1, 5)));
         if (p.kind == PAWN)
            place(b, p, 1, 6);
         else
            place(b, p, 0, 7);
      end
      return b;
   endfunction

   function automatic board_t start_position();
      board_t     b;
      logic [2:0] back [8] = '{ROOK, KNIGHT, BISHOP, QUEEN, KING, BISHOP, KNIGHT, ROOK};
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b[f] = make_piece(1'b0, back[f]);
         b[8 + f] = make_piece(1'b0, PAWN);
         b[48 + f] = make_piece(1'b1, PAWN);
         b[56 + f] = make_piece(1'b1, back[f]);
      end
      return b;
   endfunction

   function automatic board_t kings_only();
      board_t b;
      b = '0;
      b[4] = make_piece(1'b0, KING);
      b[60] = make_piece(1'b1, KING);
      return b;
   endfunction

   // Scoring rules, straight from the square list
   function automatic eval_result_t model(input board_t b, input logic wtm);
      int           mg;
      int           eg;
      int           mat;
      int           heavy;
      int           minor;
      int           occupied;
      int           phase;
      int           sgn;
      int           adv;
      int           cnt [16];   // Pawns per file, white then black
      longint       scaled;
      piece_t       sq;
      eval_result_t r;
      mg = 0;
      eg = 0;
      mat = 0;
      heavy = 0;
      minor = 0;
      occupied = 0;
      for (int k = 0; k < 16; k++)
         cnt[k] = 0;
      for (int i = 0; i < 64; i++)
      begin
         sq = b[i];
         if (sq.kind == EMPTY)
            continue;
         occupied++;
         sgn = sq.black ? -1 : 1;
         mg += sgn * MG_VALUE[sq.kind];
         eg += sgn * EG_VALUE[sq.kind];
         mat += sgn * MAT_VALUE[sq.kind];
         if (sq.kind == PAWN || sq.kind == ROOK || sq.kind == QUEEN)
            heavy++;
         if (sq.kind == KNIGHT || sq.kind == BISHOP)
            minor++;
         if (sq.kind == PAWN)
         begin
            cnt[int'(sq.black) * 8 + i % 8]++;
            adv = sq.black ? 6 - i / 8 : i / 8 - 1;
            mg += sgn * adv * PAWN_ADV_MG;
            eg += sgn * adv * PAWN_ADV_EG;
         end
      end
      for (int k = 0; k < 16; k++)
         if (cnt[k] > 1)
         begin
            sgn = (k < 8) ? 1 : -1;
            mg -= sgn * (cnt[k] - 1) * DOUBLED_MG;
            eg -= sgn * (cnt[k] - 1) * DOUBLED_EG;
         end
      phase = (occupied < PHASE_MAX) ? occupied : PHASE_MAX;
      scaled = longint'(mg) * phase + longint'(eg) * (PHASE_MAX - phase);
      scaled = scaled * PHASE_RECIP / (longint'(1) << PHASE_SHIFT);   // Truncates toward zero
      if (!wtm)
         scaled = -scaled;
      r.eval = EVAL_WIDTH'(scaled);
      r.material = 16'(mat);
      r.insufficient_material = (heavy == 0) && (minor <= 1);
      return r;
   endfunction

   // One full four-phase transaction with a random hold after ack
   task automatic run_request(input board_t b, input logic wtm);
      eval_result_t exp;
      int           hold;
      exp = model(b, wtm);
      hold = $urandom_range(0, 10);
      @(posedge clk);
      req <= 1'b1;
      request <= '{board: b, white_to_move: wtm};
      do
         @(posedge clk);
      while (ack !== 1'b1);
      checks += 3;
      assert (result.eval === exp.eval)
      else
      begin
         $display("MISMATCH eval: got %h expected %h", result.eval, exp.eval);
         errors++;
      end
      assert (result.material === exp.material)
      else
      begin
         $display("MISMATCH material: got %h expected %h", result.material, exp.material);
         errors++;
      end
      assert (result.insufficient_material === exp.insufficient_material)
      else
      begin
         $display("MISMATCH insufficient_material: got %h expected %h",
                  result.insufficient_material, exp.insufficient_material);
         errors++;
      end
      repeat (hold) @(posedge clk);
      req <= 1'b0;
      do
         @(posedge clk);
      while (ack !== 1'b0);
   endtask

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES)
      begin
         $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Checks %0d, errors %0d", checks, errors + dut.u_checker.failures + 1);
         $display("tests failed");
         $finish;
      end
   end

   initial
   begin
      void'($urandom(32'h1d97));
      reset = 1'b1;
      req = 1'b0;
      request = '0;
      errors = 0;
      checks = 0;
      cycles = 0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      repeat (3) @(posedge clk);   // Idle with req low

      run_request(start_position(), 1'b1);
      run_request(start_position(), 1'b0);

      for (int i = 0; i < 30; i++)
      begin
         brd = random_board();
         side = 1'($urandom_range(0, 1));
         run_request(brd, side);
         if (i % 5 == 0)
            run_request(brd, !side);   // Same board, other side to move
      end

      brd = kings_only();
      run_request(brd, 1'b1);
      brd[1] = make_piece(1'b0, KNIGHT);
      run_request(brd, 1'b0);
      brd = kings_only();
      brd[12] = make_piece(1'b0, PAWN);
      run_request(brd, 1'b1);
      brd = kings_only();
      brd[2] = make_piece(1'b0, BISHOP);
      brd[5] = make_piece(1'b0, BISHOP);
      run_request(brd, 1'b1);

      // Tripled white pawns against an advanced black pawn
      brd = kings_only();
      brd[10] = make_piece(1'b0, PAWN);
      brd[18] = make_piece(1'b0, PAWN);
      brd[26] = make_piece(1'b0, PAWN);
      brd[22] = make_piece(1'b1, PAWN);
      run_request(brd, 1'b1);
      run_request(brd, 1'b0);
      brd = kings_only();
      brd[43] = make_piece(1'b1, PAWN);
      brd[35] = make_piece(1'b1, PAWN);
      brd[15] = make_piece(1'b1, PAWN);
      brd[40] = make_piece(1'b0, PAWN);
      run_request(brd, 1'b0);

      repeat (2) @(posedge clk);
      total = errors + dut.u_checker.failures;
      $display("Checks %0d, errors %0d", checks, total);
      if (total == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/chess_pkg.sv
verilog/popcount.sv
verilog/eval_material.sv
verilog/eval_pawns.sv
verilog/evaluate.sv
verilog/eval_top.sv
test/eval_checker.sv
test/tb_eval.sv
